// File: design/dma_ctrl_pkg.sv
//==============================
// DMA stream control package
// Sizes, register map and shared types
//==============================
package dma_ctrl_pkg;

    // Sizes
    localparam int NUM_STREAMS  = 4;
    localparam int CHAN_W       = 2;     // Channel index width
    localparam int FRAME_SIZE_W = 16;
    localparam int ADDR_W       = 8;     // Wishbone byte address
    localparam int DATA_W       = 32;
    localparam int OFS_W        = 4;     // Register offset within a channel

    localparam logic [FRAME_SIZE_W-1:0] DEFAULT_FSIZE = 16'd32;

    // Register offsets inside one channel group
    localparam logic [OFS_W-1:0] REG_CTRL_STATUS_OFS = 4'h0;  // R: error, W: clear and width
    localparam logic [OFS_W-1:0] REG_FSIZE_OFS       = 4'h4;  // Frame size
    localparam logic [OFS_W-1:0] REG_SAMP_CNT_OFS    = 4'h8;  // W clears the count
    localparam logic [OFS_W-1:0] REG_PKT_CNT_OFS     = 4'hC;  // W clears the count

    localparam logic [DATA_W-1:0] UNMAPPED_DATA = 32'hFFFF_FFFF;

    // Control/status bit positions
    localparam int CTRL_CLEAR_BIT = 0;   // Write side, clear DMA queues
    localparam int CTRL_ERR_BIT   = 0;   // Read side, stream error
    localparam int CTRL_BUF64_BIT = 4;   // 1 = 64-bit buffer, 0 = 32-bit

    // Decoded register select
    typedef enum logic [2:0] {
        REG_CTRL_STATUS,
        REG_FSIZE,
        REG_SAMP_CNT,
        REG_PKT_CNT,
        REG_NONE
    } reg_sel_e;

    // One decoded bus access, broadcast to every channel
    typedef struct packed {
        logic              wr;      // Single-cycle write strobe
        logic [CHAN_W-1:0] chan;
        reg_sel_e          sel;
        logic [DATA_W-1:0] wdata;
    } reg_access_t;

    // Readback view of one channel
    typedef struct packed {
        logic [FRAME_SIZE_W-1:0] frame_size;
        logic                    buf64;
        logic                    err;
        logic [31:0]             samp_count;
        logic [31:0]             pkt_count;
    } chan_status_t;

    // Width of the access struct is 1 + CHAN_W + 3 + DATA_W bits
    // Width of the status struct is FRAME_SIZE_W + 2 + 64 bits

endpackage

// File: design/dma_readback_mux.sv
//==============================
// Readback multiplexer
// Registers the addressed register word
//==============================
`timescale 1ns/1ns

module dma_readback_mux (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                read_accept,
    input  logic [dma_ctrl_pkg::CHAN_W-1:0]     rd_chan,
    input  dma_ctrl_pkg::reg_sel_e              rd_sel,
    input  dma_ctrl_pkg::chan_status_t          status [dma_ctrl_pkg::NUM_STREAMS],
    output logic [dma_ctrl_pkg::DATA_W-1:0]     dat_r
);

    localparam int DATA_W       = dma_ctrl_pkg::DATA_W;
    localparam int FRAME_SIZE_W = dma_ctrl_pkg::FRAME_SIZE_W;

    dma_ctrl_pkg::chan_status_t chan_view;
    logic [DATA_W-1:0]          rd_word;

    assign chan_view = status[rd_chan];

    always_comb begin
        rd_word = '0;
        case (rd_sel)
            dma_ctrl_pkg::REG_CTRL_STATUS: begin
                rd_word[dma_ctrl_pkg::CTRL_ERR_BIT]   = chan_view.err;
                rd_word[dma_ctrl_pkg::CTRL_BUF64_BIT] = chan_view.buf64;
            end
            dma_ctrl_pkg::REG_FSIZE: begin
                rd_word = {{(DATA_W-FRAME_SIZE_W){1'b0}}, chan_view.frame_size};
            end
            dma_ctrl_pkg::REG_SAMP_CNT: rd_word = chan_view.samp_count;
            dma_ctrl_pkg::REG_PKT_CNT:  rd_word = chan_view.pkt_count;
            default:                    rd_word = dma_ctrl_pkg::UNMAPPED_DATA;
        endcase
    end

    // Captured on the accept edge, held while ack is up
    always_ff @(posedge clk) begin
        if (reset) begin
            dat_r <= '0;
        end else if (read_accept) begin
            dat_r <= rd_word;
        end
    end

endmodule

// File: design/dma_reg_decode.sv
//==============================
// Wishbone classic slave front end
// Address decode and single-cycle ack
//==============================
`timescale 1ns/1ns

module dma_reg_decode (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [dma_ctrl_pkg::ADDR_W-1:0]     adr,
    input  logic [dma_ctrl_pkg::DATA_W-1:0]     dat_w,
    output logic                                ack,
    output dma_ctrl_pkg::reg_access_t           access,
    output logic                                read_accept,
    output logic [dma_ctrl_pkg::CHAN_W-1:0]     rd_chan,
    output dma_ctrl_pkg::reg_sel_e              rd_sel
);

    localparam int OFS_W  = dma_ctrl_pkg::OFS_W;
    localparam int CHAN_W = dma_ctrl_pkg::CHAN_W;
    localparam int ADDR_W = dma_ctrl_pkg::ADDR_W;

    logic                   accept;
    logic [OFS_W-1:0]       ofs;
    logic [CHAN_W-1:0]      chan;
    logic                   top_zero;
    dma_ctrl_pkg::reg_sel_e sel;

    // New request only while no ack is outstanding
    assign accept = cyc && stb && !ack;

    // Address split
    assign ofs      = adr[OFS_W-1:0];
    assign chan     = adr[OFS_W+CHAN_W-1:OFS_W];
    assign top_zero = (adr[ADDR_W-1:OFS_W+CHAN_W] == '0);  // Upper field must be clear

    always_comb begin
        sel = dma_ctrl_pkg::REG_NONE;
        if (top_zero) begin
            case (ofs)
                dma_ctrl_pkg::REG_CTRL_STATUS_OFS: sel = dma_ctrl_pkg::REG_CTRL_STATUS;
                dma_ctrl_pkg::REG_FSIZE_OFS:       sel = dma_ctrl_pkg::REG_FSIZE;
                dma_ctrl_pkg::REG_SAMP_CNT_OFS:    sel = dma_ctrl_pkg::REG_SAMP_CNT;
                dma_ctrl_pkg::REG_PKT_CNT_OFS:     sel = dma_ctrl_pkg::REG_PKT_CNT;
                default:                           sel = dma_ctrl_pkg::REG_NONE;
            endcase
        end
    end

    // Broadcast write, unmapped writes dropped here
    assign access.wr    = accept && we && (sel != dma_ctrl_pkg::REG_NONE);
    assign access.chan  = chan;
    assign access.sel   = sel;
    assign access.wdata = dat_w;

    // Read side goes to the readback mux, unmapped reads included
    assign read_accept = accept && !we;
    assign rd_chan     = chan;
    assign rd_sel      = sel;

    // Every accepted request is acked for exactly one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;
        end
    end

endmodule

// File: design/dma_stream_ctrl.sv
//==============================
// DMA stream control register block
// Wishbone slave over four stream channels
//==============================
`timescale 1ns/1ns

module dma_stream_ctrl (
    input  logic                                    clk,
    input  logic                                    reset,
    // Wishbone classic slave
    input  logic                                    cyc,
    input  logic                                    stb,
    input  logic                                    we,
    input  logic [dma_ctrl_pkg::ADDR_W-1:0]         adr,
    input  logic [dma_ctrl_pkg::DATA_W-1:0]         dat_w,
    output logic                                    ack,
    output logic [dma_ctrl_pkg::DATA_W-1:0]         dat_r,
    // Datapath side
    input  logic [dma_ctrl_pkg::NUM_STREAMS-1:0]    packet_stb,
    input  logic [dma_ctrl_pkg::NUM_STREAMS-1:0]    sample_stb,
    input  logic [dma_ctrl_pkg::NUM_STREAMS-1:0]    stream_err,
    output logic [dma_ctrl_pkg::NUM_STREAMS-1:0]    set_clear,
    output logic [dma_ctrl_pkg::FRAME_SIZE_W-1:0]   frame_size [dma_ctrl_pkg::NUM_STREAMS],
    output logic [2:0]                              swap_lanes [dma_ctrl_pkg::NUM_STREAMS]
);

    dma_ctrl_pkg::reg_access_t              access;
    logic                                   read_accept;
    logic [dma_ctrl_pkg::CHAN_W-1:0]        rd_chan;
    dma_ctrl_pkg::reg_sel_e                 rd_sel;
    dma_ctrl_pkg::chan_status_t             status [dma_ctrl_pkg::NUM_STREAMS];

    dma_reg_decode decode_i (
        .clk         (clk),
        .reset       (reset),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .ack         (ack),
        .access      (access),
        .read_accept (read_accept),
        .rd_chan     (rd_chan),
        .rd_sel      (rd_sel)
    );

    // One register group per stream
    for (genvar i = 0; i < dma_ctrl_pkg::NUM_STREAMS; i++) begin : g_stream
        dma_stream_regs #(.CHAN_ID(i)) stream_i (
            .clk        (clk),
            .reset      (reset),
            .access     (access),
            .packet_stb (packet_stb[i]),
            .sample_stb (sample_stb[i]),
            .stream_err (stream_err[i]),
            .set_clear  (set_clear[i]),
            .frame_size (frame_size[i]),
            .swap_lanes (swap_lanes[i]),
            .status     (status[i])
        );
    end

    dma_readback_mux readback_i (
        .clk         (clk),
        .reset       (reset),
        .read_accept (read_accept),
        .rd_chan     (rd_chan),
        .rd_sel      (rd_sel),
        .status      (status),
        .dat_r       (dat_r)
    );

endmodule

// File: design/dma_stream_regs.sv
//==============================
// Per-stream settings and counters
// Frame size, buffer width, clear pulse
//==============================
`timescale 1ns/1ns

module dma_stream_regs #(
    parameter int CHAN_ID = 0  // This channel's index on the bus
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  dma_ctrl_pkg::reg_access_t               access,
    input  logic                                    packet_stb,
    input  logic                                    sample_stb,
    input  logic                                    stream_err,
    output logic                                    set_clear,
    output logic [dma_ctrl_pkg::FRAME_SIZE_W-1:0]   frame_size,
    output logic [2:0]                              swap_lanes,
    output dma_ctrl_pkg::chan_status_t              status
);

    localparam int CHAN_W       = dma_ctrl_pkg::CHAN_W;
    localparam int FRAME_SIZE_W = dma_ctrl_pkg::FRAME_SIZE_W;

    logic        hit;
    logic        buf64;
    logic [31:0] samp_count;
    logic [31:0] pkt_count;

    // Write addressed to this channel
    assign hit = access.wr && (access.chan == CHAN_W'(CHAN_ID));

    // Settings and the self-clearing queue clear
    always_ff @(posedge clk) begin
        if (reset) begin
            set_clear  <= 1'b0;
            buf64      <= 1'b1;                        // 64-bit buffer out of reset
            frame_size <= dma_ctrl_pkg::DEFAULT_FSIZE;
        end else begin
            set_clear <= 1'b0;                         // Pulse lasts one cycle
            if (hit) begin
                case (access.sel)
                    dma_ctrl_pkg::REG_CTRL_STATUS: begin
                        set_clear <= access.wdata[dma_ctrl_pkg::CTRL_CLEAR_BIT];
                        buf64     <= access.wdata[dma_ctrl_pkg::CTRL_BUF64_BIT];
                    end
                    dma_ctrl_pkg::REG_FSIZE: begin
                        frame_size <= access.wdata[FRAME_SIZE_W-1:0];
                        set_clear  <= 1'b1;            // New frame size flushes queues
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Strobe counters, a register write clears ahead of a strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            samp_count <= '0;
            pkt_count  <= '0;
        end else begin
            if (hit && access.sel == dma_ctrl_pkg::REG_SAMP_CNT) begin
                samp_count <= '0;
            end else if (sample_stb) begin
                samp_count <= samp_count + 32'd1;
            end

            if (hit && access.sel == dma_ctrl_pkg::REG_PKT_CNT) begin
                pkt_count <= '0;
            end else if (packet_stb) begin
                pkt_count <= pkt_count + 32'd1;
            end
        end
    end

    // Only 32 and 64-bit buffers supported
    assign swap_lanes = {~buf64, 2'b00};

    assign status.frame_size = frame_size;
    assign status.buf64      = buf64;
    assign status.err        = stream_err;   // Live flag from the datapath
    assign status.samp_count = samp_count;
    assign status.pkt_count  = pkt_count;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the DMA stream control testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sim.f \
    --top-module dma_stream_ctrl_tb \
    --Mdir obj_dir \
    -o dma_stream_ctrl_sim

./obj_dir/dma_stream_ctrl_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: sim.f
design/dma_ctrl_pkg.sv
design/dma_reg_decode.sv
design/dma_stream_regs.sv
design/dma_readback_mux.sv
design/dma_stream_ctrl.sv
tests/dma_stream_ctrl_properties.sv
tests/dma_stream_ctrl_tb.sv

// File: tests/dma_ctrl_patterns.txt
# test op chan offset data expected (all hex except test)
# W expected is set_clear, C data/expected are frame_size/swap_lanes, S data 0 is random
1 R 0 04 0 00000020
1 R 3 04 0 00000020
1 R 1 08 0 00000000
1 R 2 0c 0 00000000
1 R 0 00 0 00000010
1 R 3 00 0 00000010
1 C 0 00 20 0
1 C 3 00 20 0
2 W 2 04 0001abcd 4
2 R 2 04 0 0000abcd
2 C 2 00 abcd 0
2 R 1 04 0 00000020
2 C 1 00 20 0
3 S 1 08 5 0
3 S 1 0c 3 0
3 R 1 08 0 00000005
3 R 1 0c 0 00000003
3 R 0 08 0 00000000
3 R 2 0c 0 00000000
3 W 1 08 0 0
3 R 1 08 0 00000000
3 R 1 0c 0 00000003
3 W 1 0c 0 0
3 R 1 0c 0 00000000
4 W 1 00 00000001 2
4 C 1 00 20 4
4 R 1 00 0 00000000
4 E 0 00 2 0
4 R 1 00 0 00000001
4 R 0 00 0 00000010
4 W 1 00 00000010 0
4 C 1 00 20 0
4 E 0 00 0 0
4 R 1 00 0 00000010
5 R 0 02 0 ffffffff
5 R 3 0e 0 ffffffff
5 R 0 40 0 ffffffff
5 R 2 c4 0 ffffffff
5 W 2 c4 00001234 0
5 W 0 06 00005678 0
5 R 2 04 0 0000abcd
5 R 0 04 0 00000020
5 C 2 00 abcd 0
6 S 0 08 0 0
6 S 1 0c 0 0
6 S 2 08 0 0
6 S 3 0c 0 0
6 S 0 08 0 0
6 S 3 0c 0 0
6 T 0 08 0 0
6 T 1 0c 0 0
6 T 2 08 0 0
6 T 3 0c 0 0
6 T 1 08 0 0

// File: tests/dma_stream_ctrl_properties.sv
//==============================
// Bus and clear pulse properties
//==============================
`timescale 1ns/1ns

module dma_stream_ctrl_properties (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 cyc,
    input logic                                 stb,
    input logic                                 ack,
    input logic [dma_ctrl_pkg::NUM_STREAMS-1:0] set_clear
);

    // Ack lasts exactly one cycle
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack high for two cycles in a row");

    // Only a request raises ack
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        ack |-> $past(cyc && stb))
        else $error("ack without a preceding request");

    // Queue clear is a single-cycle pulse per stream
    clear_pulse: assert property (@(posedge clk) disable iff (reset)
        (set_clear & $past(set_clear)) == '0)
        else $error("set_clear high for two consecutive cycles");

endmodule

bind dma_stream_ctrl dma_stream_ctrl_properties props_i (
    .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .ack(ack), .set_clear(set_clear)
);

// File: tests/dma_stream_ctrl_tb.sv
//==============================
// Testbench for the DMA stream control block
// Pattern driven bus and strobe checks
//==============================
`timescale 1ns/1ns

module dma_stream_ctrl_tb;

    localparam int NS = dma_ctrl_pkg::NUM_STREAMS;

    logic        clk = 1'b0;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat_w;
    logic        ack;
    logic [31:0] dat_r;
    logic [NS-1:0] packet_stb;
    logic [NS-1:0] sample_stb;
    logic [NS-1:0] stream_err;
    logic [NS-1:0] set_clear;
    logic [15:0] frame_size [NS];
    logic [2:0]  swap_lanes [NS];

    // Pattern lines, one entry per operation
    int          pat_test [$];
    logic [7:0]  pat_op [$];
    logic [31:0] pat_chan [$];
    logic [31:0] pat_ofs [$];
    logic [31:0] pat_data [$];
    logic [31:0] pat_exp [$];

    logic [31:0] samp_total [NS];  // Running burst sums per stream
    logic [31:0] pkt_total [NS];
    logic [31:0] rng_state;
    logic        lines_loaded = 1'b0;
    int          total_errors = 0;
    int          test_errors = 0;
    int          checks = 0;
    int          tests_run = 0;

    dma_stream_ctrl dut_i (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .ack(ack), .dat_r(dat_r), .packet_stb(packet_stb),
        .sample_stb(sample_stb), .stream_err(stream_err), .set_clear(set_clear),
        .frame_size(frame_size), .swap_lanes(swap_lanes)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string test_title(input int t);
        case (t)
            1: return "reset values";
            2: return "frame size write";
            3: return "strobe counters";
            4: return "control and error flag";
            5: return "unmapped access";
            6: return "random strobe bursts";
            default: return "extra";
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[FAIL] t=%0t ns %s expected 0x%h got 0x%h", $time, name, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic load_patterns();
        int          fd;
        string       line;
        int          t;
        logic [7:0]  op;
        logic [31:0] c, o, d, e;
        fd = $fopen("tests/dma_ctrl_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open pattern file tests/dma_ctrl_patterns.txt");
            total_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin   // Skip column notes
                    if ($sscanf(line, "%d %s %h %h %h %h", t, op, c, o, d, e) == 6) begin
                        pat_test.push_back(t);
                        pat_op.push_back(op);
                        pat_chan.push_back(c);
                        pat_ofs.push_back(o);
                        pat_data.push_back(d);
                        pat_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
        if (pat_op.size() == 0) begin
            $display("pattern file holds no operations");
            total_errors++;
        end
    endtask

    // Single Wishbone access, called at a falling edge
    task automatic bus_access(input logic write, input logic [7:0] a, input logic [31:0] d,
                              output logic [31:0] rdata, output logic [NS-1:0] clr);
        logic got_ack;
        int   n;
        rdata   = '0;
        clr     = '0;
        got_ack = 1'b0;
        cyc     = 1'b1;
        stb     = 1'b1;
        we      = write;
        adr     = a;
        dat_w   = d;
        for (n = 0; n < 8 && !got_ack; n++) begin
            @(negedge clk);
            if (ack) begin
                got_ack = 1'b1;
                rdata   = dat_r;   // Valid only while ack is up
                clr     = set_clear;
            end
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        assert (got_ack) else begin
            $display("no ack from bus slave at t=%0t ns, address 0x%h", $time, a);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic strobe_burst(input logic [1:0] ch, input logic sample, input int len);
        int k;
        for (k = 0; k < len; k++) begin
            if (sample) sample_stb[ch] = 1'b1;
            else        packet_stb[ch] = 1'b1;
            @(negedge clk);              // One rising edge per strobe cycle
        end
        sample_stb = '0;
        packet_stb = '0;
        if (sample) samp_total[ch] = samp_total[ch] + 32'(len);
        else        pkt_total[ch]  = pkt_total[ch] + 32'(len);
    endtask

    task automatic run_pattern(input int i);
        logic [31:0]   rdata;
        logic [NS-1:0] clr;
        logic [1:0]    ch;
        logic [7:0]    a;
        int            len;
        ch = pat_chan[i][1:0];
        a  = {2'b00, pat_chan[i][1:0], 4'h0} | pat_ofs[i][7:0];
        case (pat_op[i])
            "W": begin
                bus_access(1'b1, a, pat_data[i], rdata, clr);
                check_word("set_clear", pat_exp[i], 32'(clr));
                @(negedge clk);
                check_word("set_clear after pulse", 32'h0, 32'(set_clear));
                if (a[7:6] == 2'b00 && a[3:0] == 4'h8) samp_total[ch] = '0;
                if (a[7:6] == 2'b00 && a[3:0] == 4'hC) pkt_total[ch] = '0;
            end
            "R": begin
                bus_access(1'b0, a, 32'h0, rdata, clr);
                check_word("dat_r", pat_exp[i], rdata);
            end
            "T": begin
                bus_access(1'b0, a, 32'h0, rdata, clr);
                check_word("dat_r burst total",
                           (a[3:0] == 4'h8) ? samp_total[ch] : pkt_total[ch], rdata);
            end
            "S": begin
                len = int'(pat_data[i]);
                if (len == 0) begin      // Zero length asks for an LCG pick
                    rng_state = lcg_next(rng_state);
                    len = int'(rng_state[19:16]) + 1;
                end
                strobe_burst(ch, pat_ofs[i][3:0] == 4'h8, len);
            end
            "E": begin
                stream_err = pat_data[i][NS-1:0];
                @(negedge clk);
            end
            "C": begin
                check_word($sformatf("frame_size[%0d]", ch), {16'h0, pat_data[i][15:0]},
                           {16'h0, frame_size[ch]});
                check_word($sformatf("swap_lanes[%0d]", ch), {29'h0, pat_exp[i][2:0]},
                           {29'h0, swap_lanes[ch]});
                check_word("set_clear idle", 32'h0, 32'(set_clear));
            end
            default: begin
                $display("unknown operation in pattern line %0d", i);
                test_errors++;
                total_errors++;
            end
        endcase
    endtask

    task automatic report_test(input int t);
        tests_run++;
        $display("test %0d %s: %s, %0d errors", t, test_title(t),
                 (test_errors == 0) ? "ok" : "errors seen", test_errors);
    endtask

    initial begin
        int cur_test;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        packet_stb = '0;
        sample_stb = '0;
        stream_err = '0;
        reset      = 1'b1;
        rng_state  = 32'h7c47;
        for (int s = 0; s < NS; s++) begin
            samp_total[s] = '0;
            pkt_total[s]  = '0;
        end
        load_patterns();
        lines_loaded = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        cur_test = -1;
        for (int i = 0; i < pat_op.size(); i++) begin
            if (pat_test[i] != cur_test) begin
                if (cur_test >= 0) report_test(cur_test);
                cur_test    = pat_test[i];
                test_errors = 0;
            end
            run_pattern(i);
        end
        if (cur_test >= 0) report_test(cur_test);
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the pattern count
    initial begin
        wait (lines_loaded);
        repeat (pat_op.size() * 40 + 8) @(posedge clk);
        $display("watchdog expired before the pattern run finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
